// ==== Makefile ====
# reorder buffer simulation with Verilator

TOP = rob_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f rob.f

# the run passes only when the pass message shows up in the output
run: build
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "*** TEST PASSED ***"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f rob.f

clean:
	rm -rf obj_dir

// ==== rob.f ====
rob_pkg.sv
rob_entry.sv
rob_dispatch.sv
rob_commit.sv
rob_top.sv
rob_tb.sv

// ==== rob_commit.sv ====
//====================
// reorder buffer retirement unit
// owns the head pointer, presents the oldest executed instruction to the
// retirement rename table and raises flush on a mispredicted branch
//====================

`timescale 1ns/1ns

module rob_commit (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [rob_pkg::rob_size-1:0] entry_busy,
	input  logic [rob_pkg::rob_size-1:0] entry_executed,
	input  logic [rob_pkg::rob_size-1:0] entry_is_branch,   // zero except at the head
	input  logic [rob_pkg::rob_size-1:0] entry_mispredict,  // zero except at the head
	input  rob_pkg::arn_t         entry_arn [rob_pkg::rob_size],
	input  rob_pkg::prn_t         entry_prn [rob_pkg::rob_size],
	input  rob_pkg::pc_t          entry_pc [rob_pkg::rob_size],
	input  logic                  commit_ready,     // rename table can take a retirement
	output logic [rob_pkg::rob_size-1:0] head_select,
	output logic                  commit_fire,
	output logic                  flush,
	output logic                  commit_valid,
	output rob_pkg::arn_t         commit_arn,
	output rob_pkg::prn_t         commit_prn,
	output rob_pkg::pc_t          commit_pc,
	output logic                  commit_is_branch,
	output logic                  commit_mispredict
);

	rob_pkg::rob_index_t head;                      // oldest instruction in the ring
	logic                head_busy;                 // the head entry holds an instruction
	logic                head_executed;             // and that instruction has finished

	always_comb
	begin
		head_select = '0;
		head_select[head] = 1'b1;                   // one-hot copy of the head pointer
	end

	assign head_busy = |(entry_busy & head_select);
	assign head_executed = |(entry_executed & head_select);

	// only the head drives nonzero fields so a plain OR selects it
	assign commit_is_branch = |entry_is_branch;
	assign commit_mispredict = |entry_mispredict;

	always_comb
	begin
		commit_arn = '0;
		commit_prn = '0;
		commit_pc = '0;
		for (int i = 0; i < rob_pkg::rob_size; i++)
		begin
			commit_arn = commit_arn | entry_arn[i];
			commit_prn = commit_prn | entry_prn[i];
			commit_pc = commit_pc | entry_pc[i];
		end
	end

	assign commit_valid = head_busy && head_executed;   // holds steady while ready is low
	assign commit_fire = commit_valid && commit_ready;
	assign flush = commit_fire && commit_mispredict;    // younger work is on the wrong path

	always_ff @(posedge clock)
	begin
		if (reset || flush)
			head <= '0;                             // tail also restarts at 0 after a flush
		else if (commit_fire)
			head <= head + 1'b1;                    // wraps with the 4 bit index
	end

endmodule

// ==== rob_dispatch.sv ====
//====================
// reorder buffer allocator
// owns the tail pointer and occupancy count, takes dispatch groups of up
// to two instructions and steers them into free entries
//====================

`timescale 1ns/1ns

module rob_dispatch (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  inst1_valid,
	input  logic                  inst2_valid,     // only meaningful together with inst1_valid
	input  rob_pkg::pc_t          inst1_pc,
	input  rob_pkg::arn_t         inst1_arn,
	input  rob_pkg::prn_t         inst1_prn,
	input  logic                  inst1_is_branch,
	input  rob_pkg::pc_t          inst2_pc,
	input  rob_pkg::arn_t         inst2_arn,
	input  rob_pkg::prn_t         inst2_prn,
	input  logic                  inst2_is_branch,
	output logic                  dispatch_ready,
	output rob_pkg::rob_index_t   inst1_rob_index,
	output rob_pkg::rob_index_t   inst2_rob_index,
	output logic [rob_pkg::rob_size-1:0] load1_select,
	output logic [rob_pkg::rob_size-1:0] load2_select,
	output rob_pkg::pc_t          load1_pc,
	output rob_pkg::arn_t         load1_arn,
	output rob_pkg::prn_t         load1_prn,
	output logic                  load1_is_branch,
	output rob_pkg::pc_t          load2_pc,
	output rob_pkg::arn_t         load2_arn,
	output rob_pkg::prn_t         load2_prn,
	output logic                  load2_is_branch,
	input  logic                  commit_fire,     // one entry leaves at this edge
	input  logic                  flush            // mispredict retirement empties the buffer
);

	rob_pkg::rob_index_t tail;                      // next free entry in program order
	rob_pkg::rob_count_t count;                     // entries currently in use
	rob_pkg::rob_count_t dispatch_num;              // instructions accepted this cycle
	rob_pkg::rob_count_t count_next;
	logic                accept1;                   // slot 1 transfers at this edge
	logic                accept2;                   // slot 2 transfers at this edge

	// two free entries are needed since a group may carry two instructions
	assign dispatch_ready = (count <= rob_pkg::rob_count_t'(rob_pkg::rob_size - 2));

	assign accept1 = dispatch_ready && inst1_valid;
	assign accept2 = accept1 && inst2_valid;

	assign inst1_rob_index = tail;
	assign inst2_rob_index = tail + 1'b1;           // the ring is a power of two so this wraps

	// the payload fans out to every entry, the select vectors pick the receiver
	assign load1_pc = inst1_pc;
	assign load1_arn = inst1_arn;
	assign load1_prn = inst1_prn;
	assign load1_is_branch = inst1_is_branch;
	assign load2_pc = inst2_pc;
	assign load2_arn = inst2_arn;
	assign load2_prn = inst2_prn;
	assign load2_is_branch = inst2_is_branch;

	always_comb
	begin
		load1_select = '0;
		load2_select = '0;
		if (accept1)
			load1_select[inst1_rob_index] = 1'b1;   // decode the tail into a one-hot load
		if (accept2)
			load2_select[inst2_rob_index] = 1'b1;
	end

	always_comb
	begin
		dispatch_num = '0;
		if (accept2)
			dispatch_num = rob_pkg::rob_count_t'(2);
		else if (accept1)
			dispatch_num = rob_pkg::rob_count_t'(1);
		count_next = count + dispatch_num - rob_pkg::rob_count_t'(commit_fire);
	end

	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			tail <= '0;                             // any group offered during a flush is dropped
			count <= '0;
		end
		else
		begin
			tail <= tail + rob_pkg::rob_index_t'(dispatch_num);
			count <= count_next;
		end
	end

endmodule

// ==== rob_entry.sv ====
//====================
// reorder buffer entry
// holds one instruction's retirement record plus its executed and
// mispredict state, and shows its fields only while it is the head
//====================

`timescale 1ns/1ns

module rob_entry (
	input  logic              clock,
	input  logic              reset,
	input  logic              load1,               // slot 1 of the dispatch group lands here
	input  logic              load2,               // slot 2 of the dispatch group lands here
	input  rob_pkg::pc_t      load1_pc,
	input  rob_pkg::arn_t     load1_arn,
	input  rob_pkg::prn_t     load1_prn,
	input  logic              load1_is_branch,
	input  rob_pkg::pc_t      load2_pc,
	input  rob_pkg::arn_t     load2_arn,
	input  rob_pkg::prn_t     load2_prn,
	input  logic              load2_is_branch,
	input  rob_pkg::rob_index_t entry_index,       // this entry's own position in the ring
	input  logic              complete_valid,
	input  rob_pkg::rob_index_t complete_rob_index,
	input  logic              complete_mispredict,
	input  logic              head_select,         // this entry is the oldest one
	input  logic              commit_fire,         // the head retires at this edge
	input  logic              clear,               // flush of the whole buffer
	output logic              busy,
	output logic              executed,
	output logic              is_branch_out,
	output logic              mispredict_out,
	output rob_pkg::arn_t     arn_out,
	output rob_pkg::prn_t     prn_out,
	output rob_pkg::pc_t      pc_out
);

	rob_pkg::pc_t  pc;                              // stored program counter
	rob_pkg::arn_t arn;                             // stored architected destination
	rob_pkg::prn_t prn;                             // stored physical destination
	logic          is_branch;                       // stored branch flag
	logic          mispredict;                      // branch resolved against the prediction
	logic          complete_hit;                    // completion addresses this live entry

	assign complete_hit = complete_valid && busy && (complete_rob_index == entry_index);

	// fields read as zero off the head so the commit side can OR every entry together
	assign is_branch_out = head_select ? is_branch : 1'b0;
	assign mispredict_out = head_select ? mispredict : 1'b0;
	assign arn_out = head_select ? arn : '0;
	assign prn_out = head_select ? prn : '0;
	assign pc_out = head_select ? pc : '0;

	always_ff @(posedge clock)
	begin
		if (reset || clear)
		begin
			busy <= 1'b0;                           // flush empties every entry at once
			executed <= 1'b0;
			mispredict <= 1'b0;
		end
		else if (load1 || load2)
		begin
			busy <= 1'b1;                           // a fresh instruction has not executed yet
			executed <= 1'b0;
			mispredict <= 1'b0;
		end
		else if (head_select && commit_fire)
		begin
			busy <= 1'b0;                           // retired, the slot is free next cycle
			executed <= 1'b0;
			mispredict <= 1'b0;
		end
		else if (complete_hit)
		begin
			executed <= 1'b1;                       // result now sits in the physical register
			mispredict <= complete_mispredict;
		end
	end

	always_ff @(posedge clock)
	begin
		if (load1)
		begin
			pc <= load1_pc;                         // slot 1 wins if both loads point here
			arn <= load1_arn;
			prn <= load1_prn;
			is_branch <= load1_is_branch;
		end
		else if (load2)
		begin
			pc <= load2_pc;
			arn <= load2_arn;
			prn <= load2_prn;
			is_branch <= load2_is_branch;
		end
	end

endmodule

// ==== rob_pkg.sv ====
//====================
// reorder buffer package
// sizes, index widths and field types shared by the buffer blocks
//====================

package rob_pkg;

	localparam int rob_size = 16;                          // entries in the buffer
	localparam int rob_index_width = $clog2(rob_size);     // 4 bits address any entry
	localparam int rob_count_width = rob_index_width + 1;  // one extra bit so a full buffer reads 16

	localparam int prf_size = 64;                          // physical register file depth
	localparam int prn_width = $clog2(prf_size);           // 6 bit physical register number
	localparam int arn_width = 5;                          // 32 architected registers
	localparam int pc_width = 32;                          // full byte address

	typedef logic [rob_index_width-1:0] rob_index_t;       // position of an entry in the ring
	typedef logic [rob_count_width-1:0] rob_count_t;       // occupancy, 0 up to rob_size
	typedef logic [prn_width-1:0] prn_t;                   // physical destination register
	typedef logic [arn_width-1:0] arn_t;                   // architected destination register
	typedef logic [pc_width-1:0] pc_t;                     // program counter of the instruction

endpackage

// ==== rob_tb.sv ====
//====================
// reorder buffer testbench
// directed and seeded random tests checked against a queue model of the buffer
//====================

`timescale 1ns/1ns

module rob_tb;

	localparam int clock_period = 100;
	localparam int test_cycles = 450;                  // reset plus directed and random tests
	localparam int margin_cycles = 150;

	logic                clock = 1'b0;
	logic                reset = 1'b1;
	logic                inst1_valid = 1'b0;
	logic                inst2_valid = 1'b0;
	rob_pkg::pc_t        inst1_pc = '0;
	rob_pkg::arn_t       inst1_arn = '0;
	rob_pkg::prn_t       inst1_prn = '0;
	logic                inst1_is_branch = 1'b0;
	rob_pkg::pc_t        inst2_pc = '0;
	rob_pkg::arn_t       inst2_arn = '0;
	rob_pkg::prn_t       inst2_prn = '0;
	logic                inst2_is_branch = 1'b0;
	logic                complete_valid = 1'b0;
	rob_pkg::rob_index_t complete_rob_index = '0;
	logic                complete_mispredict = 1'b0;
	logic                commit_ready = 1'b0;
	logic                dispatch_ready;
	rob_pkg::rob_index_t inst1_rob_index;
	rob_pkg::rob_index_t inst2_rob_index;
	logic                commit_valid;
	rob_pkg::arn_t       commit_arn;
	rob_pkg::prn_t       commit_prn;
	rob_pkg::pc_t        commit_pc;
	logic                commit_is_branch;
	logic                commit_mispredict;
	logic                flush;

	rob_pkg::pc_t        m_pc [rob_pkg::rob_size];     // model copy of every entry's record
	rob_pkg::arn_t       m_arn [rob_pkg::rob_size];
	rob_pkg::prn_t       m_prn [rob_pkg::rob_size];
	logic [rob_pkg::rob_size-1:0] m_br = '0;
	logic [rob_pkg::rob_size-1:0] m_busy = '0;
	logic [rob_pkg::rob_size-1:0] m_exec = '0;
	logic [rob_pkg::rob_size-1:0] m_misp = '0;
	rob_pkg::rob_index_t order [$];                    // live indices with the oldest first
	rob_pkg::rob_index_t m_tail = '0;
	rob_pkg::pc_t        pc_next = 32'h0000_1000;
	integer              seed = 32'h7fc6e415;
	int                  value_errors = 0;
	int                  protocol_errors = 0;
	int                  flushes = 0;                  // flushes raised by the DUT

	rob_top u_dut (.*);

	always #(clock_period / 2) clock = ~clock;

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	task automatic compare_bit(input logic got, input logic expected, input string what);
		if (got !== expected)
		begin
			value_errors++;
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic compare_index(input rob_pkg::rob_index_t got,
			input rob_pkg::rob_index_t expected, input string what);
		if (got !== expected)
		begin
			value_errors++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic compare_count(input rob_pkg::rob_count_t got,
			input rob_pkg::rob_count_t expected, input string what);
		if (got !== expected)
		begin
			value_errors++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic compare_commit(input rob_pkg::arn_t arn, input rob_pkg::prn_t prn,
			input rob_pkg::pc_t pc, input logic is_branch, input logic mispredict);
		if (commit_arn !== arn || commit_prn !== prn || commit_pc !== pc ||
				commit_is_branch !== is_branch || commit_mispredict !== mispredict)
		begin
			value_errors++;
			$write("Error at %0t ns: retired pc %h arn %0d prn %0d br %b mp %b",
				$time, commit_pc, commit_arn, commit_prn, commit_is_branch, commit_mispredict);
			$display(", expected %h %0d %0d %b %b", pc, arn, prn, is_branch, mispredict);
		end
	endtask

	task automatic record_entry(input rob_pkg::pc_t pc, input rob_pkg::arn_t arn,
			input rob_pkg::prn_t prn, input logic is_branch);
		m_pc[m_tail] = pc;
		m_arn[m_tail] = arn;
		m_prn[m_tail] = prn;
		m_br[m_tail] = is_branch;
		m_busy[m_tail] = 1'b1;
		m_exec[m_tail] = 1'b0;                         // a load wipes any old completion state
		m_misp[m_tail] = 1'b0;
		order.push_back(m_tail);
		m_tail = m_tail + 1'b1;
	endtask

	// checks the outputs mid cycle and then steps the model through the coming edge
	task automatic run_cycle();
		logic exp_ready;
		logic exp_valid;
		logic fire;
		logic exp_flush;
		rob_pkg::rob_index_t head;
		#(clock_period / 2);
		exp_ready = order.size() <= rob_pkg::rob_size - 2;
		head = (order.size() > 0) ? order[0] : '0;
		exp_valid = (order.size() > 0) && m_exec[head];
		fire = exp_valid && commit_ready;
		exp_flush = fire && m_misp[head];
		compare_bit(dispatch_ready, exp_ready, "dispatch_ready");
		compare_index(inst1_rob_index, m_tail, "inst1_rob_index");
		compare_index(inst2_rob_index, m_tail + 1'b1, "inst2_rob_index");
		compare_bit(flush, exp_flush, "flush");
		if (flush === 1'b1)
			flushes++;
		if (commit_valid !== exp_valid)
		begin
			protocol_errors++;
			if (exp_valid)
				$display("missing retirement: entry %0d was due to retire at %0t ns", head, $time);
			else
				$display("unexpected retirement of pc %h offered at %0t ns", commit_pc, $time);
		end
		else if (exp_valid)
			compare_commit(m_arn[head], m_prn[head], m_pc[head], m_br[head], m_misp[head]);
		if (exp_flush)
		begin
			order.delete();                            // the group offered now is dropped too
			m_busy = '0;
			m_exec = '0;
			m_tail = '0;
		end
		else
		begin
			if (complete_valid && m_busy[complete_rob_index] &&
					!(fire && complete_rob_index == head))
			begin
				m_exec[complete_rob_index] = 1'b1;
				m_misp[complete_rob_index] = complete_mispredict;
			end
			if (fire)
			begin
				m_busy[head] = 1'b0;
				void'(order.pop_front());
			end
			if (exp_ready && inst1_valid)
			begin
				record_entry(inst1_pc, inst1_arn, inst1_prn, inst1_is_branch);
				if (inst2_valid)
					record_entry(inst2_pc, inst2_arn, inst2_prn, inst2_is_branch);
			end
		end
		@(posedge clock);
		#10;                                           // new stimulus lands just after the edge
		inst1_valid = 1'b0;
		inst2_valid = 1'b0;
		complete_valid = 1'b0;
		complete_mispredict = 1'b0;
	endtask

	task automatic offer_group(input logic valid2, input logic branch1, input logic branch2);
		inst1_valid = 1'b1;
		inst1_pc = pc_next;
		inst1_arn = rob_pkg::arn_t'($random(seed));
		inst1_prn = rob_pkg::prn_t'($random(seed));
		inst1_is_branch = branch1;
		inst2_valid = valid2;
		inst2_pc = pc_next + 32'd4;
		inst2_arn = rob_pkg::arn_t'($random(seed));
		inst2_prn = rob_pkg::prn_t'($random(seed));
		inst2_is_branch = branch2;
		pc_next = pc_next + 32'd8;
	endtask

	task automatic complete_entry(input rob_pkg::rob_index_t index, input logic mispredict);
		complete_valid = 1'b1;
		complete_rob_index = index;
		complete_mispredict = mispredict;
		run_cycle();
	endtask

	// finishes every outstanding instruction and waits for the buffer to empty
	task automatic drain();
		rob_pkg::rob_index_t pending [$];
		int cycles;
		commit_ready = 1'b1;
		pending = order;
		foreach (pending[i])
			if (m_busy[pending[i]] && !m_exec[pending[i]])
				complete_entry(pending[i], 1'b0);
		cycles = 0;
		while ((order.size() > 0 || commit_valid !== 1'b0) && cycles < 40)
		begin
			run_cycle();
			cycles++;
		end
		if (order.size() > 0 || commit_valid !== 1'b0)
		begin
			protocol_errors++;
			$display("the buffer was still retiring instructions after draining");
		end
	endtask

	task automatic test_reset_state();
		compare_bit(dispatch_ready, 1'b1, "dispatch_ready after reset");
		compare_bit(commit_valid, 1'b0, "commit_valid after reset");
		compare_bit(flush, 1'b0, "flush after reset");
		compare_index(inst1_rob_index, '0, "first inst1 index");
		compare_index(inst2_rob_index, rob_pkg::rob_index_t'(1), "first inst2 index");
		offer_group(1'b1, 1'b0, 1'b0);
		run_cycle();
		drain();
	endtask

	task automatic test_in_order();
		rob_pkg::rob_index_t ids [$];
		commit_ready = 1'b1;
		repeat (3)
		begin
			offer_group(1'b1, 1'b0, 1'b0);
			run_cycle();
		end
		ids = order;
		for (int k = ids.size() - 1; k >= 0; k--)
			complete_entry(ids[k], 1'b0);              // completes the youngest first
		drain();
	endtask

	task automatic test_full();
		int accepted;
		accepted = 0;
		commit_ready = 1'b0;
		while (dispatch_ready && accepted < 20)
		begin
			offer_group(1'b0, 1'b0, 1'b0);
			accepted++;
			run_cycle();
		end
		compare_bit(dispatch_ready, 1'b0, "dispatch_ready with a full buffer");
		compare_count(rob_pkg::rob_count_t'(accepted),
			rob_pkg::rob_count_t'(rob_pkg::rob_size - 1), "instructions held by a full buffer");
		drain();
		offer_group(1'b1, 1'b0, 1'b0);                 // tail and head have wrapped by now
		run_cycle();
		drain();
	endtask

	task automatic test_backpressure();
		commit_ready = 1'b0;
		offer_group(1'b1, 1'b0, 1'b0);
		run_cycle();
		complete_entry(order[0], 1'b0);
		repeat (4)
		begin
			compare_bit(commit_valid, 1'b1, "commit_valid under back-pressure");
			run_cycle();
		end
		commit_ready = 1'b1;
		run_cycle();                                   // the held head retires here
		compare_bit(commit_valid, 1'b0, "commit_valid after the held head retired");
		drain();
	endtask

	task automatic test_flush();
		rob_pkg::rob_index_t ids [$];
		int start_flushes;
		int cycles;
		commit_ready = 1'b1;
		offer_group(1'b1, 1'b1, 1'b0);                 // branch leads the group
		run_cycle();
		offer_group(1'b1, 1'b0, 1'b0);
		run_cycle();
		ids = order;
		for (int k = 1; k < ids.size(); k++)
			complete_entry(ids[k], 1'b0);
		start_flushes = flushes;
		complete_entry(ids[0], 1'b1);
		cycles = 0;
		while (flushes == start_flushes && cycles < 10)
		begin
			offer_group(1'b1, 1'b1, 1'b0);             // offered during the flush and dropped
			run_cycle();
			cycles++;
		end
		if (flushes == start_flushes)
		begin
			protocol_errors++;
			$display("the mispredicted branch never retired with a flush");
		end
		compare_index(inst1_rob_index, '0, "first index after a flush");
		repeat (3)
			run_cycle();
		offer_group(1'b1, 1'b1, 1'b0);
		run_cycle();
		drain();
	endtask

	task automatic test_random();
		rob_pkg::rob_index_t pending [$];
		repeat (300)
		begin
			commit_ready = (rand_below(4) != 0);
			if (rand_below(2) == 1)
				offer_group(rand_below(2) == 1, rand_below(8) == 0, rand_below(8) == 0);
			pending.delete();
			foreach (order[i])
				if (!m_exec[order[i]])
					pending.push_back(order[i]);
			if (pending.size() > 0 && rand_below(3) != 0)
			begin
				complete_valid = 1'b1;
				complete_rob_index = pending[rand_below(pending.size())];
				complete_mispredict = m_br[complete_rob_index] && (rand_below(4) == 0);
			end
			run_cycle();
		end
		drain();
	endtask

	initial
	begin
		repeat (5) @(posedge clock);
		#10;
		reset = 1'b0;
		test_reset_state();
		test_in_order();
		test_full();
		test_backpressure();
		test_flush();
		test_random();
		$display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		#((test_cycles + margin_cycles) * clock_period);
		$display("watchdog expired: the tests did not finish in %0d cycles",
			test_cycles + margin_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== rob_top.sv ====
//====================
// reorder buffer top level
// allocator, sixteen entries and the retirement unit
//====================

`timescale 1ns/1ns

module rob_top (
	input  logic                clock,
	input  logic                reset,
	input  logic                inst1_valid,
	input  logic                inst2_valid,
	input  rob_pkg::pc_t        inst1_pc,
	input  rob_pkg::arn_t       inst1_arn,
	input  rob_pkg::prn_t       inst1_prn,
	input  logic                inst1_is_branch,
	input  rob_pkg::pc_t        inst2_pc,
	input  rob_pkg::arn_t       inst2_arn,
	input  rob_pkg::prn_t       inst2_prn,
	input  logic                inst2_is_branch,
	output logic                dispatch_ready,
	output rob_pkg::rob_index_t inst1_rob_index,
	output rob_pkg::rob_index_t inst2_rob_index,
	input  logic                complete_valid,
	input  rob_pkg::rob_index_t complete_rob_index,
	input  logic                complete_mispredict,
	input  logic                commit_ready,
	output logic                commit_valid,
	output rob_pkg::arn_t       commit_arn,
	output rob_pkg::prn_t       commit_prn,
	output rob_pkg::pc_t        commit_pc,
	output logic                commit_is_branch,
	output logic                commit_mispredict,
	output logic                flush
);

	logic [rob_pkg::rob_size-1:0] load1_select;     // one-hot target of slot 1
	logic [rob_pkg::rob_size-1:0] load2_select;     // one-hot target of slot 2
	rob_pkg::pc_t                 load1_pc;
	rob_pkg::arn_t                load1_arn;
	rob_pkg::prn_t                load1_prn;
	logic                         load1_is_branch;
	rob_pkg::pc_t                 load2_pc;
	rob_pkg::arn_t                load2_arn;
	rob_pkg::prn_t                load2_prn;
	logic                         load2_is_branch;
	logic [rob_pkg::rob_size-1:0] head_select;      // one-hot head from the retirement unit
	logic                         commit_fire;
	logic [rob_pkg::rob_size-1:0] entry_busy;
	logic [rob_pkg::rob_size-1:0] entry_executed;
	logic [rob_pkg::rob_size-1:0] entry_is_branch;
	logic [rob_pkg::rob_size-1:0] entry_mispredict;
	rob_pkg::arn_t                entry_arn [rob_pkg::rob_size];
	rob_pkg::prn_t                entry_prn [rob_pkg::rob_size];
	rob_pkg::pc_t                 entry_pc [rob_pkg::rob_size];

	rob_dispatch u_dispatch (
		.clock           (clock),
		.reset           (reset),
		.inst1_valid     (inst1_valid),
		.inst2_valid     (inst2_valid),
		.inst1_pc        (inst1_pc),
		.inst1_arn       (inst1_arn),
		.inst1_prn       (inst1_prn),
		.inst1_is_branch (inst1_is_branch),
		.inst2_pc        (inst2_pc),
		.inst2_arn       (inst2_arn),
		.inst2_prn       (inst2_prn),
		.inst2_is_branch (inst2_is_branch),
		.dispatch_ready  (dispatch_ready),
		.inst1_rob_index (inst1_rob_index),
		.inst2_rob_index (inst2_rob_index),
		.load1_select    (load1_select),
		.load2_select    (load2_select),
		.load1_pc        (load1_pc),
		.load1_arn       (load1_arn),
		.load1_prn       (load1_prn),
		.load1_is_branch (load1_is_branch),
		.load2_pc        (load2_pc),
		.load2_arn       (load2_arn),
		.load2_prn       (load2_prn),
		.load2_is_branch (load2_is_branch),
		.commit_fire     (commit_fire),
		.flush           (flush)
	);

	for (genvar i = 0; i < rob_pkg::rob_size; i++)
	begin : g_entry
		rob_entry u_entry (
			.clock               (clock),
			.reset               (reset),
			.load1               (load1_select[i]),
			.load2               (load2_select[i]),
			.load1_pc            (load1_pc),
			.load1_arn           (load1_arn),
			.load1_prn           (load1_prn),
			.load1_is_branch     (load1_is_branch),
			.load2_pc            (load2_pc),
			.load2_arn           (load2_arn),
			.load2_prn           (load2_prn),
			.load2_is_branch     (load2_is_branch),
			.entry_index         (rob_pkg::rob_index_t'(i)),
			.complete_valid      (complete_valid),
			.complete_rob_index  (complete_rob_index),
			.complete_mispredict (complete_mispredict),
			.head_select         (head_select[i]),
			.commit_fire         (commit_fire),
			.clear               (flush),
			.busy                (entry_busy[i]),
			.executed            (entry_executed[i]),
			.is_branch_out       (entry_is_branch[i]),
			.mispredict_out      (entry_mispredict[i]),
			.arn_out             (entry_arn[i]),
			.prn_out             (entry_prn[i]),
			.pc_out              (entry_pc[i])
		);
	end

	rob_commit u_commit (
		.clock             (clock),
		.reset             (reset),
		.entry_busy        (entry_busy),
		.entry_executed    (entry_executed),
		.entry_is_branch   (entry_is_branch),
		.entry_mispredict  (entry_mispredict),
		.entry_arn         (entry_arn),
		.entry_prn         (entry_prn),
		.entry_pc          (entry_pc),
		.commit_ready      (commit_ready),
		.head_select       (head_select),
		.commit_fire       (commit_fire),
		.flush             (flush),
		.commit_valid      (commit_valid),
		.commit_arn        (commit_arn),
		.commit_prn        (commit_prn),
		.commit_pc         (commit_pc),
		.commit_is_branch  (commit_is_branch),
		.commit_mispredict (commit_mispredict)
	);

endmodule
